// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module leaf_tb -f tb.f -o leaf_sim || exit 1
out=$(./obj_dir/leaf_sim 2>&1)
echo "$out"
echo "$out" | grep -qx "Test passed" && exit 0 || exit 1

// File: tb.f
verilog/leaf_pkg.sv
verilog/leaf_interface.sv
verilog/read_queue.sv
verilog/write_queue.sv
verilog/weight_stream.sv
verilog/mva_kernel.sv
verilog/leaf.sv
verification/leaf_tb.sv

// File: verification/leaf_tb.sv
`default_nettype none

module leaf_tb;
    import leaf_pkg::*;

    logic    clk;
    logic    rst_n;
    logic    ap_start;
    logic    resend;
    packet_t din_leaf_bft2interface;
    packet_t dout_leaf_interface2bft;

    packet_t expected_q [$];
    string   name_q [$];
    string   test_name;

    leaf dut (
        .clk                     (clk),
        .rst_n                   (rst_n),
        .din_leaf_bft2interface  (din_leaf_bft2interface),
        .dout_leaf_interface2bft (dout_leaf_interface2bft),
        .resend                  (resend),
        .ap_start                (ap_start)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic check(input string name, input packet_t expected, input packet_t actual);
        if (actual !== expected) begin
            $display("ERR %s expected=%h actual=%h", name, expected, actual);
            $display("Test failed");
            $fatal(1, "Output packet mismatch.");
        end
    endtask

    task automatic reject_line(input string line);
        $display("Trace line could not be parsed: %s", line);
        $display("Test failed");
        $fatal(1, "Bad trace line.");
    endtask

    task automatic drive_cycle(input logic start, input logic rs, input packet_t pkt);
        @(posedge clk);
        ap_start               <= start;
        resend                 <= rs;
        din_leaf_bft2interface <= pkt;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            din_leaf_bft2interface <= '0;  // Resend and ap_start keep their level.
        end
    endtask

    // Sampled on the falling edge, away from the driving edge.
    initial begin
        packet_t exp_pkt;
        string   exp_name;
        forever begin
            @(negedge clk);
            if (rst_n && resend) begin
                check({test_name, "_resend"}, '0, dout_leaf_interface2bft);
            end else if (rst_n && dout_leaf_interface2bft.vld) begin
                if (expected_q.size() == 0) begin
                    $display("Output packet %h arrived when none was expected.",
                             dout_leaf_interface2bft);
                    $display("Test failed");
                    $fatal(1, "Unexpected output packet.");
                end else begin
                    exp_pkt  = expected_q.pop_front();
                    exp_name = name_q.pop_front();
                    check(exp_name, exp_pkt, dout_leaf_interface2bft);
                end
            end
        end
    end

    initial begin
        int         fd;
        int         n;
        int         idle_n;
        int         cycles;
        string      line;
        logic [7:0] kind;
        logic       start_v;
        logic       resend_v;
        logic       vld_v;
        leaf_id_t   leaf_v;
        port_id_t   port_v;
        word_t      payload_v;
        packet_t    pkt;

        rst_n                  <= 1'b0;
        ap_start               <= 1'b0;
        resend                 <= 1'b0;
        din_leaf_bft2interface <= '0;
        test_name = "reset";

        fd = $fopen("verification/leaf_trace.txt", "r");
        if (fd == 0) begin
            $display("Trace file verification/leaf_trace.txt could not be opened.");
            $display("Test failed");
            $fatal(1, "Missing trace file.");
        end

        repeat (4) @(posedge clk);
        rst_n <= 1'b1;

        while ($fgets(line, fd) != 0) begin
            if (line.len() > 0 && line.getc(line.len() - 1) == 8'h0a) begin
                line = line.substr(0, line.len() - 2);
            end
            if (line.len() == 0) continue;
            kind = line.getc(0);
            case (kind)
                "#": begin
                end
                "T": test_name = line.substr(2, line.len() - 1);
                "P": begin
                    n = $sscanf(line, "P %d %d %d %d %d %h", start_v, resend_v, vld_v,
                                leaf_v, port_v, payload_v);
                    if (n != 6) reject_line(line);
                    pkt           = '0;
                    pkt.vld       = vld_v;
                    pkt.dest_leaf = leaf_v;
                    pkt.dest_port = port_v;
                    pkt.payload   = payload_v;
                    drive_cycle(start_v, resend_v, pkt);
                end
                "E": begin
                    n = $sscanf(line, "E %d %d %h", leaf_v, port_v, payload_v);
                    if (n != 3) reject_line(line);
                    pkt           = '0;
                    pkt.vld       = 1'b1;
                    pkt.dest_leaf = leaf_v;
                    pkt.dest_port = port_v;
                    pkt.payload   = payload_v;  // Address stays 0.
                    expected_q.push_back(pkt);
                    name_q.push_back(test_name);
                end
                "I": begin
                    n = $sscanf(line, "I %d", idle_n);
                    if (n != 1) reject_line(line);
                    idle_cycles(idle_n);
                end
                default: reject_line(line);
            endcase
        end
        $fclose(fd);
        idle_cycles(1);

        cycles = 0;
        while (expected_q.size() != 0 && cycles < 2000) begin
            @(posedge clk);
            cycles++;
        end
        idle_cycles(20);  // Room for a stray extra packet to show up.

        if (expected_q.size() == 0) begin
            $display("Test passed");
            $finish;
        end else begin
            $display("Timeout: %0d expected packets never arrived.", expected_q.size());
            $display("Test failed");
            $fatal(1, "Timeout waiting for output packets.");
        end
    end

endmodule

`default_nettype wire

// File: verification/leaf_trace.txt
# P ap_start resend vld dest_leaf dest_port payload_hex, one input cycle
# E dest_leaf dest_port payload_hex expected output, I idle_cycles, T test_name
T pre_cfg
P 1 0 1 2 1 00000010
P 1 0 1 2 1 00000020
P 1 0 1 2 1 00000030
P 1 0 1 2 1 00000040
I 20
T cfg_route
P 1 0 1 2 0 00000093
E 9 3 00000010
E 9 3 00000040
E 9 3 00000090
E 9 3 00000100
I 20
T sets_resend
E 9 3 55555555
E 9 3 cccccccc
E 9 3 07000000
E 9 3 00000038
E 9 3 40000000
E 9 3 0000001e
E 9 3 b0000000
E 9 3 ffffffe8
P 1 0 1 2 1 11111111
P 1 0 1 2 1 22222222
P 1 0 1 2 1 01000000
P 1 0 1 2 1 00000007
P 1 0 1 2 1 40000000
P 1 0 1 2 1 00000003
P 1 0 1 2 1 10000000
P 1 0 1 2 1 fffffffe
P 1 1 0 0 0 00000000
I 12
P 1 0 0 0 0 00000000
I 30
T ignored
P 0 0 1 2 1 deadbeef
P 0 0 1 2 0 00000055
P 1 0 1 2 2 12345678
P 1 0 1 2 7 00000099
I 30
T after_ignored
E 9 3 fffffff3
E 9 3 0000001c
E 9 3 000f000f
E 9 3 000000a0
P 1 0 1 2 1 ffffffff
P 1 0 1 2 1 00000002
P 1 0 1 2 1 00010001
P 1 0 1 2 1 0000000a

// File: verilog/leaf.sv
`default_nettype none

module leaf (
    input  logic              clk,
    input  logic              rst_n,
    input  leaf_pkg::packet_t din_leaf_bft2interface,
    output leaf_pkg::packet_t dout_leaf_interface2bft,
    input  logic              resend,
    input  logic              ap_start
);
    import leaf_pkg::*;

    logic    ap_start_user;
    word_t   fifo_word;
    logic    fifo_vld;
    logic    fifo_ack;
    vector_t in_vec;
    logic    in_vec_vld;
    logic    in_vec_rdy;
    vector_t w_vec;
    logic    w_vec_vld;
    logic    w_vec_rdy;
    vector_t out_vec;
    logic    out_vec_vld;
    logic    out_vec_rdy;
    word_t   out_word;
    logic    out_word_vld;
    logic    out_word_ack;

    leaf_interface leaf_interface_inst (
        .clk                     (clk),
        .rst_n                   (rst_n),
        .ap_start                (ap_start),
        .din_leaf_bft2interface  (din_leaf_bft2interface),
        .resend                  (resend),
        .dout_leaf_interface2bft (dout_leaf_interface2bft),
        .ap_start_user           (ap_start_user),
        .dout_interface2user     (fifo_word),
        .vld_interface2user      (fifo_vld),
        .ack_user2interface      (fifo_ack),
        .din_user2interface      (out_word),
        .vld_user2interface      (out_word_vld),
        .ack_interface2user      (out_word_ack)
    );

    read_queue input_converter (
        .clk          (clk),
        .rst_n        (rst_n),
        .din          (fifo_word),
        .vld_in       (fifo_vld),
        .rdy_upward   (fifo_ack),
        .dout         (in_vec),
        .vld_out      (in_vec_vld),
        .rdy_downward (in_vec_rdy)
    );

    weight_stream weight_stream_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .dout         (w_vec),
        .vld_out      (w_vec_vld),
        .rdy_downward (w_vec_rdy)
    );

    mva_kernel mva_kernel_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .ap_start (ap_start_user),
        .in_data  (in_vec),
        .in_vld   (in_vec_vld),
        .in_rdy   (in_vec_rdy),
        .w_data   (w_vec),
        .w_vld    (w_vec_vld),
        .w_rdy    (w_vec_rdy),
        .out_data (out_vec),
        .out_vld  (out_vec_vld),
        .out_rdy  (out_vec_rdy)
    );

    write_queue output_converter (
        .clk          (clk),
        .rst_n        (rst_n),
        .din          (out_vec),
        .vld_in       (out_vec_vld),
        .rdy_upward   (out_vec_rdy),
        .dout         (out_word),
        .vld_out      (out_word_vld),
        .rdy_downward (out_word_ack)
    );

endmodule

`default_nettype wire

// File: verilog/leaf_interface.sv
`default_nettype none

module leaf_interface (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              ap_start,
    input  leaf_pkg::packet_t din_leaf_bft2interface,
    input  logic              resend,
    output leaf_pkg::packet_t dout_leaf_interface2bft,
    output logic              ap_start_user,
    output leaf_pkg::word_t   dout_interface2user,
    output logic              vld_interface2user,
    input  logic              ack_user2interface,
    input  leaf_pkg::word_t   din_user2interface,
    input  logic              vld_user2interface,
    output logic              ack_interface2user
);
    import leaf_pkg::*;

    logic               accept;
    logic               cfg_hit;
    logic               user_hit;
    route_t             route;
    logic               configured;
    word_t              fifo_mem [FIFO_DEPTH];
    logic [FIFO_AW-1:0] wr_ptr;
    logic [FIFO_AW-1:0] rd_ptr;
    logic [FIFO_AW:0]   fifo_cnt;
    logic               fifo_full;
    logic               push;
    logic               pop;
    logic               send;
    logic               out_vld_q;
    route_t             out_route_q;
    word_t              out_payload_q;

    assign accept   = ap_start && din_leaf_bft2interface.vld;
    assign cfg_hit  = accept && (din_leaf_bft2interface.dest_port == port_id_t'(CFG_PORT));
    assign user_hit = accept && (din_leaf_bft2interface.dest_port == port_id_t'(USER_PORT));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            route      <= '0;
            configured <= 1'b0;
        end else if (cfg_hit) begin
            route      <= route_t'(din_leaf_bft2interface.payload[$bits(route_t)-1:0]);
            configured <= 1'b1;
        end
    end

    assign ap_start_user = configured;

    assign fifo_full           = (fifo_cnt == (FIFO_AW+1)'(FIFO_DEPTH));
    assign push                = user_hit && !fifo_full;
    assign vld_interface2user  = (fifo_cnt != '0);
    assign pop                 = vld_interface2user && ack_user2interface;
    assign dout_interface2user = fifo_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            fifo_mem[wr_ptr] <= din_leaf_bft2interface.payload;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            fifo_cnt <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;
            if (pop) rd_ptr <= rd_ptr + 1'b1;
            if (push && !pop) fifo_cnt <= fifo_cnt + 1'b1;
            else if (pop && !push) fifo_cnt <= fifo_cnt - 1'b1;
        end
    end

    // Network side stalls the user chain during resend.
    assign ack_interface2user = !resend;
    assign send               = vld_user2interface && ack_interface2user;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_vld_q <= 1'b0;
        end else if (!resend) begin
            out_vld_q <= send;  // A packet hidden by resend is held and shown later.
        end
    end

    always_ff @(posedge clk) begin
        if (send) begin
            out_route_q   <= route;
            out_payload_q <= din_user2interface;
        end
    end

    always_comb begin
        dout_leaf_interface2bft = '0;
        if (!resend) begin
            dout_leaf_interface2bft.vld       = out_vld_q;
            dout_leaf_interface2bft.dest_leaf = out_route_q.leaf;
            dout_leaf_interface2bft.dest_port = out_route_q.port;
            dout_leaf_interface2bft.payload   = out_payload_q;
        end
    end

    a_no_push_when_full: assert property (
        @(posedge clk) disable iff (!rst_n) !(user_hit && fifo_full)
    ) else $error("User packet dropped, input FIFO full.");

    a_no_output_before_cfg: assert property (
        @(posedge clk) disable iff (!rst_n) out_vld_q |-> configured
    ) else $error("Output packet sent before configuration.");

endmodule

`default_nettype wire

// File: verilog/leaf_pkg.sv
`default_nettype none

package leaf_pkg;

    localparam int WORD_W          = 32;
    localparam int LANES           = 4;
    localparam int VECTOR_W        = WORD_W * LANES;
    localparam int LEAF_W          = 5;
    localparam int PORT_W          = 4;
    localparam int ADDR_W          = 7;
    localparam int CFG_PORT        = 0;
    localparam int USER_PORT       = 1;
    localparam int FIFO_DEPTH      = 16;
    localparam int FIFO_AW         = $clog2(FIFO_DEPTH);
    localparam int LANE_CNT_W      = $clog2(LANES);
    localparam int NUM_WEIGHT_SETS = 4;
    localparam int WSET_W          = $clog2(NUM_WEIGHT_SETS);

    typedef logic [WORD_W-1:0]   word_t;
    typedef logic [VECTOR_W-1:0] vector_t;  // Lane 0 in the low word.
    typedef logic [LEAF_W-1:0]   leaf_id_t;
    typedef logic [PORT_W-1:0]   port_id_t;
    typedef logic [ADDR_W-1:0]   addr_t;

    typedef struct packed {
        logic     vld;
        leaf_id_t dest_leaf;
        port_id_t dest_port;
        addr_t    addr;
        word_t    payload;
    } packet_t;

    typedef struct packed {
        leaf_id_t leaf;
        port_id_t port;
    } route_t;

    // Set s, lane i holds 4s + i + 1.
    localparam vector_t WEIGHT_TABLE [NUM_WEIGHT_SETS] = '{
        {32'd4,  32'd3,  32'd2,  32'd1},
        {32'd8,  32'd7,  32'd6,  32'd5},
        {32'd12, 32'd11, 32'd10, 32'd9},
        {32'd16, 32'd15, 32'd14, 32'd13}
    };

endpackage

`default_nettype wire

// File: verilog/mva_kernel.sv
`default_nettype none

module mva_kernel (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              ap_start,
    input  leaf_pkg::vector_t in_data,
    input  logic              in_vld,
    output logic              in_rdy,
    input  leaf_pkg::vector_t w_data,
    input  logic              w_vld,
    output logic              w_rdy,
    output leaf_pkg::vector_t out_data,
    output logic              out_vld,
    input  logic              out_rdy
);
    import leaf_pkg::*;

    logic    space;
    logic    fire;
    word_t   prod [LANES];
    vector_t result;

    assign space  = !out_vld || out_rdy;  // Register empty or draining.
    assign in_rdy = ap_start && w_vld && space;
    assign w_rdy  = ap_start && in_vld && space;
    assign fire   = ap_start && in_vld && w_vld && space;

    for (genvar i = 0; i < LANES; i++) begin : g_lane
        assign prod[i] = in_data[i*WORD_W +: WORD_W] * w_data[i*WORD_W +: WORD_W];  // Low word.
        assign result[i*WORD_W +: WORD_W] = prod[i];
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            out_data <= result;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_vld <= 1'b0;
        end else if (fire) begin
            out_vld <= 1'b1;
        end else if (out_rdy) begin
            out_vld <= 1'b0;
        end
    end

    // Result waits in the register until the write queue takes it.
    a_hold_result: assert property (
        @(posedge clk) disable iff (!rst_n)
        (out_vld && !out_rdy) |=> (out_vld && $stable(out_data))
    ) else $error("Kernel result changed while waiting for the write queue.");

endmodule

`default_nettype wire

// File: verilog/read_queue.sv
`default_nettype none

module read_queue (
    input  logic              clk,
    input  logic              rst_n,
    input  leaf_pkg::word_t   din,
    input  logic              vld_in,
    output logic              rdy_upward,
    output leaf_pkg::vector_t dout,
    output logic              vld_out,
    input  logic              rdy_downward
);
    import leaf_pkg::*;

    vector_t               vec_q;
    logic [LANE_CNT_W-1:0] cnt;
    logic                  full;

    assign rdy_upward = !full;
    assign vld_out    = full;
    assign dout       = vec_q;

    always_ff @(posedge clk) begin
        if (vld_in && rdy_upward) begin
            vec_q[cnt*WORD_W +: WORD_W] <= din;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt  <= '0;
            full <= 1'b0;
        end else if (vld_in && rdy_upward) begin
            cnt <= cnt + 1'b1;
            if (cnt == LANE_CNT_W'(LANES-1)) full <= 1'b1;  // Last lane written.
        end else if (full && rdy_downward) begin
            full <= 1'b0;
        end
    end

    a_hold_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        (vld_out && !rdy_downward) |=> (vld_out && $stable(dout))
    ) else $error("Vector changed while waiting for the kernel.");

endmodule

`default_nettype wire

// File: verilog/weight_stream.sv
`default_nettype none

module weight_stream (
    input  logic              clk,
    input  logic              rst_n,
    output leaf_pkg::vector_t dout,
    output logic              vld_out,
    input  logic              rdy_downward
);
    import leaf_pkg::*;

    logic [WSET_W-1:0] set_q;

    assign dout = WEIGHT_TABLE[set_q];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            set_q   <= '0;
            vld_out <= 1'b0;
        end else begin
            vld_out <= 1'b1;
            if (vld_out && rdy_downward) begin
                if (set_q == WSET_W'(NUM_WEIGHT_SETS-1)) set_q <= '0;
                else set_q <= set_q + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/write_queue.sv
`default_nettype none

module write_queue (
    input  logic              clk,
    input  logic              rst_n,
    input  leaf_pkg::vector_t din,
    input  logic              vld_in,
    output logic              rdy_upward,
    output leaf_pkg::word_t   dout,
    output logic              vld_out,
    input  logic              rdy_downward
);
    import leaf_pkg::*;

    vector_t               vec_q;
    logic [LANE_CNT_W-1:0] cnt;
    logic                  full;

    assign rdy_upward = !full;
    assign vld_out    = full;
    assign dout       = vec_q[cnt*WORD_W +: WORD_W];

    always_ff @(posedge clk) begin
        if (vld_in && rdy_upward) begin
            vec_q <= din;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt  <= '0;
            full <= 1'b0;
        end else if (vld_in && rdy_upward) begin
            full <= 1'b1;
        end else if (full && rdy_downward) begin
            cnt <= cnt + 1'b1;
            if (cnt == LANE_CNT_W'(LANES-1)) full <= 1'b0;  // Lane 3 gone.
        end
    end

endmodule

`default_nettype wire
